/* Makefile */
# Verilator build and run of the keypad testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --top-module tb_keypad_top -Mdir obj_dir -f all.f
	./obj_dir/Vtb_keypad_top | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
hdl/keypad_pkg.sv
hdl/keypad_scanner.sv
hdl/key_debouncer.sv
hdl/key_event_fifo.sv
hdl/keypad_top.sv
test/keypad_matrix_model.sv
test/tb_keypad_top.sv

/* hdl/key_debouncer.sv */
// Accepts a key after DEBOUNCE_CYCLES steady readings and emits one push per press.
// A new press needs a full release run of DEBOUNCE_CYCLES low readings first.
`timescale 1ns/1ns
`default_nettype none

module key_debouncer
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       hit,
    input  logic [3:0] hit_code,
    output logic       push,
    output logic [3:0] push_code,
    output logic       busy
);

    typedef enum logic [1:0] {
        IDLE,
        PRESS_WAIT,
        HELD,
        RELEASE_WAIT
    } deb_state_t;

    deb_state_t  state;
    logic [15:0] cnt;
    logic [3:0]  cand_code;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
            push  <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                IDLE: begin
                    if (hit) begin
                        state <= PRESS_WAIT;
                        cnt   <= '0;
                    end
                end
                PRESS_WAIT: begin
                    if (!hit) begin
                        state <= IDLE;
                    end else if (hit_code != cand_code) begin
                        cnt <= '0;              // Another key, start over
                    end else if (cnt == DEBOUNCE_CYCLES - 16'd1) begin
                        state <= HELD;
                        push  <= 1'b1;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                HELD: begin
                    if (!hit) begin
                        state <= RELEASE_WAIT;
                        cnt   <= '0;
                    end
                end
                RELEASE_WAIT: begin
                    if (hit) begin
                        state <= HELD;          // Dropout, no new event
                    end else if (cnt == DEBOUNCE_CYCLES - 16'd1) begin
                        state <= IDLE;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Candidate follows the scanner until the press is accepted
    always_ff @(posedge clk) begin
        if (hit && (state == IDLE || state == PRESS_WAIT)) begin
            cand_code <= hit_code;
        end
    end

    assign push_code = cand_code;
    assign busy      = (state != IDLE);

endmodule

`default_nettype wire

/* hdl/key_event_fifo.sv */
// Key event queue with a valid/ready read side.
// A push while full is dropped; the oldest events are kept.
`timescale 1ns/1ns
`default_nettype none

module key_event_fifo
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  logic [3:0] push_code,
    output logic [3:0] key_code,
    output logic       key_valid,
    input  logic       key_ready
);

    logic [3:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full    = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = key_valid && key_ready;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_code;
        end
    end

    // Pointers wrap with the depth a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign key_valid = (count != '0);
    assign key_code  = mem[rd_ptr];         // Held until popped

endmodule

`default_nettype wire

/* hdl/keypad_pkg.sv */
// Timing and size constants shared by the keypad RTL and its testbench.
// Scan and debounce counts are shortened for simulation.
`default_nettype none

package keypad_pkg;

    // Matrix size
    localparam int NUM_ROWS = 4;
    localparam int NUM_COLS = 4;

    // Cycles each row is driven before the scan moves on
    localparam logic [7:0] SCAN_DWELL = 8'd16;

    // Column synchronizer depth; a new row is trusted only after this many cycles
    localparam logic [7:0] SYNC_STAGES = 8'd3;

    // Stable readings needed for press and for release
    // 60000 gives about 20 ms on a 3 MHz board
    localparam logic [15:0] DEBOUNCE_CYCLES = 16'd64;

    // Key event queue
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = 2;

endpackage

`default_nettype wire

/* hdl/keypad_scanner.sv */
// Drives one row low at a time and decodes a low column to a hex key code.
// Only one key per row is reported; the lowest column wins.
`timescale 1ns/1ns
`default_nettype none

module keypad_scanner
    import keypad_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_COLS-1:0] keypad_cols,
    output logic [NUM_ROWS-1:0] keypad_rows,
    output logic                hit,
    output logic [3:0]          hit_code
);

    logic [NUM_ROWS-1:0] row_q;
    logic [7:0]          dwell_cnt;
    logic [NUM_COLS-1:0] cols_s1;
    logic [NUM_COLS-1:0] cols_s2;
    logic [NUM_COLS-1:0] cols_s3;
    logic                settled;
    logic                col_low;
    logic [1:0]          row_idx;
    logic [1:0]          col_idx;

    // Layout 1 2 3 C / 4 5 6 D / 7 8 9 E / A 0 B F
    function automatic logic [3:0] key_lookup(input logic [1:0] r, input logic [1:0] c);
        logic [3:0] code;
        case ({r, c})
            4'h0: code = 4'h1;
            4'h1: code = 4'h2;
            4'h2: code = 4'h3;
            4'h3: code = 4'hc;
            4'h4: code = 4'h4;
            4'h5: code = 4'h5;
            4'h6: code = 4'h6;
            4'h7: code = 4'hd;
            4'h8: code = 4'h7;
            4'h9: code = 4'h8;
            4'ha: code = 4'h9;
            4'hb: code = 4'he;
            4'hc: code = 4'ha;
            4'hd: code = 4'h0;
            4'he: code = 4'hb;
            4'hf: code = 4'hf;
        endcase
        return code;
    endfunction

    // Columns idle high through the pull-ups
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cols_s1 <= '1;
            cols_s2 <= '1;
            cols_s3 <= '1;
        end else begin
            cols_s1 <= keypad_cols;
            cols_s2 <= cols_s1;
            cols_s3 <= cols_s2;
        end
    end

    // Rotation freezes while a key in the current row is seen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q     <= {{(NUM_ROWS-1){1'b0}}, 1'b1};
            dwell_cnt <= '0;
        end else if (!hit) begin
            if (dwell_cnt == SCAN_DWELL - 8'd1) begin
                row_q     <= {row_q[NUM_ROWS-2:0], row_q[NUM_ROWS-1]};
                dwell_cnt <= '0;
            end else begin
                dwell_cnt <= dwell_cnt + 8'd1;
            end
        end
    end

    assign keypad_rows = ~row_q;            // Active low drive

    // Synchronizer still holds the previous row's columns until then
    assign settled = (dwell_cnt >= SYNC_STAGES);

    always_comb begin
        row_idx = 2'd0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (row_q[i]) begin
                row_idx = 2'(i);
            end
        end
    end

    always_comb begin
        col_low = 1'b0;
        col_idx = 2'd0;
        for (int i = NUM_COLS - 1; i >= 0; i--) begin
            if (!cols_s3[i]) begin
                col_low = 1'b1;
                col_idx = 2'(i);            // Last write is the lowest column
            end
        end
    end

    assign hit      = settled && col_low;
    assign hit_code = key_lookup(row_idx, col_idx);

endmodule

`default_nettype wire

/* hdl/keypad_top.sv */
// 4x4 hex keypad interface with one event per debounced press.
// Rows are driven active low; columns need external pull-ups.
`timescale 1ns/1ns
`default_nettype none

module keypad_top (
    input  logic       clk,
    input  logic       rst_n,
    output logic [3:0] keypad_rows,
    input  logic [3:0] keypad_cols,
    output logic [3:0] key_code,
    output logic       key_valid,
    input  logic       key_ready,
    output logic       busy
);

    logic       hit;
    logic [3:0] hit_code;
    logic       push;
    logic [3:0] push_code;

    keypad_scanner u_scanner (
        .clk         (clk),
        .rst_n       (rst_n),
        .keypad_cols (keypad_cols),
        .keypad_rows (keypad_rows),
        .hit         (hit),
        .hit_code    (hit_code)
    );

    key_debouncer u_debouncer (
        .clk       (clk),
        .rst_n     (rst_n),
        .hit       (hit),
        .hit_code  (hit_code),
        .push      (push),
        .push_code (push_code),
        .busy      (busy)
    );

    key_event_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_code (push_code),
        .key_code  (key_code),
        .key_valid (key_valid),
        .key_ready (key_ready)
    );

endmodule

`default_nettype wire

/* test/keypad_golden.txt */
# key(row*4+col, 16 none) hold drop release ready(0 low,1 high,2 random) code(hex, 10 none)
# each of the 16 keys once
0 192 0 192 1 1
1 192 0 192 1 2
2 192 0 192 1 3
3 192 0 192 1 c
4 192 0 192 1 4
5 192 0 192 1 5
6 192 0 192 1 6
7 192 0 192 1 d
8 192 0 192 1 7
9 192 0 192 1 8
10 192 0 192 1 9
11 192 0 192 1 e
12 192 0 192 1 a
13 192 0 192 1 0
14 192 0 192 1 b
15 192 0 192 1 f
# short press, then long hold with a dropout
5 20 0 192 1 10
9 300 10 192 1 8
# six presses with ready low, only four kept
0 192 0 192 0 1
1 192 0 192 0 2
2 192 0 192 0 3
3 192 0 192 0 c
4 192 0 192 0 10
5 192 0 192 0 10
16 0 0 40 1 10
# random ready
7 192 0 192 2 d
14 192 0 192 2 b
11 192 0 192 2 e
15 192 0 192 2 f
13 192 0 192 2 0
2 192 0 192 2 3

/* test/keypad_matrix_model.sv */
// Behavioral 4x4 keypad with one key at a time.
// key_index is row*4+col; bounce opens the contact while pressed stays high.
`timescale 1ns/1ns
`default_nettype none

module keypad_matrix_model (
    input  logic [3:0] keypad_rows,
    input  logic       pressed,
    input  logic [3:0] key_index,
    input  logic       bounce,
    output logic [3:0] keypad_cols
);

    logic [1:0] row;
    logic [1:0] col;

    assign row = key_index[3:2];
    assign col = key_index[1:0];

    always_comb begin
        keypad_cols = 4'hf;                 // Pull-ups
        if (pressed && !bounce && !keypad_rows[row]) begin
            keypad_cols[col] = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* test/tb_keypad_top.sv */
// Keypad interface testbench driven by test/keypad_golden.txt, run from the project root.
// Expected codes come from the golden file and are cross-checked against a local layout.
`timescale 1ns/1ns
`default_nettype none

module tb_keypad_top
    import keypad_pkg::*;
;

    localparam int MAX_STEPS = 64;
    localparam int NO_KEY    = 16;
    localparam int NO_EVENT  = 16;
    localparam int WAIT_LIMIT = 2 * int'(DEBOUNCE_CYCLES);

    // 1 2 3 C / 4 5 6 D / 7 8 9 E / A 0 B F
    localparam logic [3:0] LAYOUT [16] = '{
        4'h1, 4'h2, 4'h3, 4'hc, 4'h4, 4'h5, 4'h6, 4'hd,
        4'h7, 4'h8, 4'h9, 4'he, 4'ha, 4'h0, 4'hb, 4'hf
    };

    logic       clk;
    logic       rst_n;
    logic [3:0] keypad_rows;
    logic [3:0] keypad_cols;
    logic [3:0] key_code;
    logic       key_valid;
    logic       key_ready;
    logic       busy;
    logic       pressed;
    logic [3:0] key_index;
    logic       bounce;

    int st_key [MAX_STEPS];
    int st_hold [MAX_STEPS];
    int st_drop [MAX_STEPS];
    int st_rel [MAX_STEPS];
    int st_rdy [MAX_STEPS];
    int st_exp [MAX_STEPS];
    int num_steps;
    int errors;
    int checks;
    int cycles;
    int limit;
    logic [3:0] rx_q [$];
    logic [3:0] exp_q [$];
    logic       prev_stall;
    logic [3:0] prev_code;

    keypad_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .keypad_rows (keypad_rows),
        .keypad_cols (keypad_cols),
        .key_code    (key_code),
        .key_valid   (key_valid),
        .key_ready   (key_ready),
        .busy        (busy)
    );

    keypad_matrix_model u_model (
        .keypad_rows (keypad_rows),
        .pressed     (pressed),
        .key_index   (key_index),
        .bounce      (bounce),
        .keypad_cols (keypad_cols)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Transfer log and stall stability
    always @(posedge clk) begin
        if (rst_n) begin
            if (prev_stall && (!key_valid || key_code != prev_code)) begin
                errors++;
                $display("FAILED at %0t: key_code changed during stall", $time);
            end
            if (key_valid && key_ready) begin
                rx_q.push_back(key_code);
            end
            prev_stall = key_valid && !key_ready;
            prev_code  = key_code;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, no result reached", cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display("tests failed");
            $finish;
        end
    end

    task automatic tick(input int mode);
        @(posedge clk);
        #2;
        if (mode == 2) begin
            key_ready = 1'($urandom % 2);
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    n;
        int    k, h, d, r, m, e;
        string line;
        fd = $fopen("test/keypad_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/keypad_golden.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && num_steps < MAX_STEPS) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %h", k, h, d, r, m, e);
                if (n == 6) begin
                    st_key[num_steps]  = k;
                    st_hold[num_steps] = h;
                    st_drop[num_steps] = d;
                    st_rel[num_steps]  = r;
                    st_rdy[num_steps]  = m;
                    st_exp[num_steps]  = e;
                    limit += h + d + r;
                    num_steps++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Waits for the expected events, then compares them in order
    task automatic compare_events(input int step);
        int w;
        w = 0;
        while (rx_q.size() < exp_q.size() && w < WAIT_LIMIT) begin
            tick(1);
            w++;
        end
        checks++;
        if (rx_q.size() != exp_q.size()) begin
            errors++;
            $display("FAILED at %0t: step %0d got %0d events, expected %0d",
                     $time, step, rx_q.size(), exp_q.size());
        end else begin
            foreach (exp_q[i]) begin
                if (rx_q[i] != exp_q[i]) begin
                    errors++;
                    $display("FAILED at %0t: step %0d event %0d code %h, expected %h",
                             $time, step, i, rx_q[i], exp_q[i]);
                end
            end
        end
        rx_q.delete();
        exp_q.delete();
    endtask

    task automatic check_busy(input int step, input logic want);
        checks++;
        if (busy !== want) begin
            errors++;
            $display("FAILED at %0t: step %0d busy %b, expected %b",
                     $time, step, busy, want);
        end
    endtask

    task automatic run_step(input int s);
        key_ready = (st_rdy[s] == 1);
        if (st_exp[s] != NO_EVENT) begin
            exp_q.push_back(4'(st_exp[s]));
            if (st_key[s] >= NO_KEY || LAYOUT[st_key[s]] != 4'(st_exp[s])) begin
                errors++;
                $display("Golden step %0d does not match the key layout", s);
            end
        end
        if (st_key[s] < NO_KEY) begin
            key_index = 4'(st_key[s]);
            pressed   = 1'b1;
        end
        for (int c = 0; c < st_hold[s]; c++) begin
            if (st_drop[s] > 0 && c == st_hold[s] / 2) begin
                bounce = 1'b1;
                repeat (st_drop[s]) tick(st_rdy[s]);
                bounce = 1'b0;
            end
            tick(st_rdy[s]);
        end
        // A long hold is past the scan latency and into the debounce
        if (st_key[s] < NO_KEY && st_hold[s] > 2 * int'(DEBOUNCE_CYCLES)) begin
            check_busy(s, 1'b1);
        end
        pressed = 1'b0;
        repeat (st_rel[s]) tick(st_rdy[s]);
        if (st_rel[s] > 2 * int'(DEBOUNCE_CYCLES)) begin
            check_busy(s, 1'b0);
        end
        if (st_rdy[s] != 0) begin
            key_ready = 1'b1;
            compare_events(s);
        end
    endtask

    initial begin
        int seed_val;
        seed_val   = $urandom(32'hfb40e1fd);
        rst_n      = 1'b0;
        key_ready  = 1'b0;
        pressed    = 1'b0;
        key_index  = 4'd0;
        bounce     = 1'b0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        num_steps  = 0;
        prev_stall = 1'b0;
        prev_code  = 4'd0;
        limit      = 200 + 10;
        load_golden();
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        checks++;
        if (key_valid || busy || $countones(~keypad_rows) != 1) begin
            errors++;
            $display("FAILED at %0t: bad state after reset rows=%b valid=%b busy=%b",
                     $time, keypad_rows, key_valid, busy);
        end
        for (int s = 0; s < num_steps; s++) begin
            run_step(s);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && num_steps > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
